/* rtl/v06c_defines.svh */
`ifndef V06C_DEFINES_SVH
`define V06C_DEFINES_SVH

// Status word bit positions
`define V06C_SW_INTA  0
`define V06C_SW_WRN   1
`define V06C_SW_STACK 2
`define V06C_SW_IOW   4
`define V06C_SW_IOR   6
`define V06C_SW_MEMR  7

// I/O port addresses, low address byte
`define V06C_PORT_JOY_BASE 8'h04
`define V06C_PORT_JOYP     8'h06
`define V06C_PORT_JOYPU    8'h07
`define V06C_PORT_JOYA     8'h0E
`define V06C_PORT_JOYB     8'h0F
`define V06C_PORT_EDSK     8'h10

// Widths and fixed values
`define V06C_RAM_AW    19
`define V06C_PAGE_W    3
`define V06C_IDLE_DATA 8'hFF

`endif

/* rtl/v06c_pkg.sv */
`include "v06c_defines.svh"

package v06c_pkg;

	// ------------------------------------------------------------
	// CPU bus cycle
	// ------------------------------------------------------------

	// Status word, bit 7 down to bit 0
	typedef struct packed {
		logic mem_rd;
		logic io_rd;
		logic m1;
		logic io_wr;
		logic halt_ack;
		logic stack;
		logic wr_n;
		logic int_ack;
	} status_word_t;

	typedef struct packed {
		status_word_t status;
		logic [15:0]  addr;
		logic [7:0]   wdata;
	} bus_cycle_t;

	typedef struct packed {
		logic io_rd;
		logic io_wr;
		logic mem_acc;
	} io_strobe_t;

	// ------------------------------------------------------------
	// Joystick
	// ------------------------------------------------------------

	// Pad bits: right, left, down, up, fire 1, fire 2, two spare
	typedef struct packed {
		logic [7:0] pad_a;
		logic [7:0] pad_b;
	} joy_pads_t;

	typedef struct packed {
		logic [7:0] p;
		logic [7:0] pu;
		logic [7:0] a;
		logic [7:0] b;
	} joy_views_t;

	typedef struct packed {
		logic       mode;
		logic [2:0] rsvd;
		logic [2:0] idx;
		logic       val;
	} joy_bitset_t;

	// Port 04 data byte, also taken raw on port 05
	typedef union packed {
		logic [7:0]  raw;
		joy_bitset_t bitset;
	} joy_cmd_u;

	// E-disk mapped RAM address
	typedef struct packed {
		logic [`V06C_PAGE_W-1:0] page;
		logic [`V06C_RAM_AW-1:0] ram_addr;
	} mem_map_t;

endpackage

/* rtl/v06c_bus_frontend.sv */
`timescale 1ns/1ps
`include "v06c_defines.svh"

module v06c_bus_frontend (
	input  logic                 clk_sys,
	input  logic                 cold_reset,
	input  logic                 req_i,
	input  v06c_pkg::bus_cycle_t cycle_i,
	input  logic [7:0]           rd_byte_i,
	output logic                 ack_o,
	output v06c_pkg::bus_cycle_t cur_o,
	output v06c_pkg::io_strobe_t strobe_o,
	output logic [7:0]           rdata_o
);
	import v06c_pkg::*;

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_EXEC = 2'd1;
	localparam logic [1:0] ST_WAIT = 2'd2;

	logic [1:0] state;
	logic       ack_q;
	bus_cycle_t cur_q;
	logic [7:0] rdata_q;
	logic [7:0] sw;
	logic       exec;
	logic       busy;
	logic       start;

	assign sw    = cur_q.status;
	assign exec  = (state == ST_EXEC);
	assign start = (state == ST_IDLE) && req_i && !ack_q;
	// Ack stays up one clock in idle, cycle still counts as live
	assign busy  = (state != ST_IDLE) || ack_q;

	always_comb begin
		strobe_o.io_rd   = exec & sw[`V06C_SW_IOR];
		strobe_o.io_wr   = exec & sw[`V06C_SW_IOW] & ~sw[`V06C_SW_WRN];
		strobe_o.mem_acc = busy & (sw[`V06C_SW_MEMR] | ~sw[`V06C_SW_WRN])
			& ~sw[`V06C_SW_IOW] & ~sw[`V06C_SW_IOR];
	end

	// Handshake FSM
	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			state <= ST_IDLE;
			ack_q <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					ack_q <= 1'b0;
					if (start)
						state <= ST_EXEC;
				end
				ST_EXEC: begin
					ack_q <= 1'b1;
					state <= ST_WAIT;
				end
				ST_WAIT: if (!req_i) state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Cycle and read byte
	always_ff @(posedge clk_sys) begin
		if (start)
			cur_q <= cycle_i;
		if (exec)
			rdata_q <= sw[`V06C_SW_INTA] ? `V06C_IDLE_DATA : rd_byte_i;
	end

	assign ack_o   = ack_q;
	assign cur_o   = cur_q;
	assign rdata_o = rdata_q;

	assert property (@(posedge clk_sys) disable iff (cold_reset)
		$rose(ack_q) |-> $past(req_i))
		else $error("ack rose with no request pending");

	assert property (@(posedge clk_sys) disable iff (cold_reset)
		strobe_o.io_wr |=> !strobe_o.io_wr)
		else $error("I/O write strobe longer than one clock");

endmodule

/* rtl/v06c_io_decode.sv */
`timescale 1ns/1ps
`include "v06c_defines.svh"

module v06c_io_decode (
	input  v06c_pkg::bus_cycle_t cur_i,
	input  v06c_pkg::io_strobe_t strobe_i,
	input  v06c_pkg::joy_views_t joy_rd_i,
	output logic [7:0]           rd_byte_o,
	output logic                 edsk_we_o,
	output logic                 joy_we_o
);
	import v06c_pkg::*;

	logic [7:0] port;
	logic       joy_sel;
	logic       edsk_sel;

	// ------------------------------------------------------------
	// Port read multiplexer
	// ------------------------------------------------------------

	// Dropped and undecoded ports float high
	function automatic logic [7:0] read_mux(
		input logic [7:0] p,
		input joy_views_t v
	);
		case (p)
			`V06C_PORT_JOY_BASE:         read_mux = 8'h00;
			`V06C_PORT_JOY_BASE + 8'h01: read_mux = 8'h00;
			`V06C_PORT_JOYP:             read_mux = v.p;
			`V06C_PORT_JOYPU:            read_mux = v.pu;
			`V06C_PORT_JOYA:             read_mux = v.a;
			`V06C_PORT_JOYB:             read_mux = v.b;
			default:                     read_mux = `V06C_IDLE_DATA;
		endcase
	endfunction

	assign port = cur_i.addr[7:0];

	// Only I/O reads put port data on the bus
	assign rd_byte_o = strobe_i.io_rd ? read_mux(port, joy_rd_i) : `V06C_IDLE_DATA;

	// ------------------------------------------------------------
	// Write enables
	// ------------------------------------------------------------

	// Joystick pair 04/05
	assign joy_sel  = ((port & 8'hFE) == `V06C_PORT_JOY_BASE);
	assign edsk_sel = (port == `V06C_PORT_EDSK);

	assign edsk_we_o = strobe_i.io_wr & edsk_sel;
	assign joy_we_o  = strobe_i.io_wr & joy_sel;

	// One register per write cycle across both blocks
	always_comb begin
		assert final (!(edsk_we_o && joy_we_o))
			else $error("E-disk and joystick writes in the same cycle");
	end

endmodule

/* rtl/v06c_edisk_map.sv */
`timescale 1ns/1ps
`include "v06c_defines.svh"

module v06c_edisk_map (
	input  logic                 clk_sys,
	input  logic                 cold_reset,
	input  v06c_pkg::bus_cycle_t cur_i,
	input  logic                 mem_acc_i,
	input  logic                 edsk_we_i,
	output v06c_pkg::mem_map_t   map_o
);
	import v06c_pkg::*;

	logic [7:0]              ed_reg;
	logic                    ed_win;
	logic                    ed_stack;
	logic                    ed_ram;
	logic [`V06C_PAGE_W-1:0] page;

	// Linear {page, addr}, then bits 14..13 moved to the bottom
	function automatic mem_map_t map_addr(
		input logic [`V06C_PAGE_W-1:0] pg,
		input logic [15:0]             addr
	);
		logic [`V06C_RAM_AW-1:0] lin;
		mem_map_t                m;
		lin        = {pg, addr};
		m.page     = pg;
		m.ram_addr = {lin[18:15], lin[12:0], lin[14:13]};
		return m;
	endfunction

	// Control register
	always_ff @(posedge clk_sys) begin
		if (cold_reset)
			ed_reg <= 8'h00;
		else if (edsk_we_i)
			ed_reg <= cur_i.wdata;
	end

	// Window in upper 32K, quarter selection by bits 7 and 6
	assign ed_win = cur_i.addr[15] & ((cur_i.addr[14] ^ cur_i.addr[13])
		| (ed_reg[7] & cur_i.addr[14] & cur_i.addr[13])
		| (ed_reg[6] & ~cur_i.addr[14] & ~cur_i.addr[13]));

	assign ed_stack = ed_reg[4] & cur_i.status[`V06C_SW_STACK] & mem_acc_i;
	assign ed_ram   = ed_reg[5] & ed_win & mem_acc_i;

	// Stack mapping wins over the window
	always_comb begin
		if (ed_stack)
			page = {1'b0, ed_reg[3:2]} + 3'd1;
		else if (ed_ram)
			page = {1'b0, ed_reg[1:0]} + 3'd1;
		else
			page = '0;
	end

	assign map_o = map_addr(page, cur_i.addr);

	assert property (@(posedge clk_sys) disable iff (cold_reset)
		map_o.page <= 3'd4)
		else $error("E-disk page out of range");

endmodule

/* rtl/v06c_joy_ports.sv */
`timescale 1ns/1ps

module v06c_joy_ports (
	input  logic                 clk_sys,
	input  logic                 cold_reset,
	input  v06c_pkg::bus_cycle_t cur_i,
	input  logic                 joy_we_i,
	input  v06c_pkg::joy_pads_t  pads_i,
	output v06c_pkg::joy_views_t views_o
);
	import v06c_pkg::*;

	logic [7:0] joy_port;
	joy_cmd_u   joy_cmd;
	logic [7:0] view_a;
	logic [7:0] view_b;
	logic [7:0] pu_or;

	// Active-low view of one pad, spare bits read as ones
	function automatic logic [7:0] pad_view(input logic [7:0] pad);
		pad_view = ~{pad[5], pad[4], 2'b00, pad[2], pad[3], pad[1], pad[0]};
	endfunction

	assign joy_cmd.raw = cur_i.wdata;

	// ------------------------------------------------------------
	// Port register
	// ------------------------------------------------------------

	// Port 05 loads the byte, port 04 sets or clears one bit
	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			joy_port <= 8'h00;
		end else if (joy_we_i) begin
			if (cur_i.addr[0])
				joy_port <= joy_cmd.raw;
			else if (!joy_cmd.bitset.mode)
				joy_port[joy_cmd.bitset.idx] <= joy_cmd.bitset.val;
		end
	end

	// ------------------------------------------------------------
	// Read views
	// ------------------------------------------------------------

	assign view_a = pad_view(pads_i.pad_a);
	assign view_b = pad_view(pads_i.pad_b);

	// Both pads merged, active high
	assign pu_or = pads_i.pad_a | pads_i.pad_b;

	always_comb begin
		views_o.a  = view_a;
		views_o.b  = view_b;
		views_o.pu = {pu_or[3], pu_or[0], pu_or[2], pu_or[1], pu_or[4], pu_or[5], 2'b00};
		// Pad select from register bits 6..5
		case (joy_port[6:5])
			2'b00:   views_o.p = view_a & view_b;
			2'b01:   views_o.p = view_a;
			2'b10:   views_o.p = view_b;
			default: views_o.p = 8'hFF;
		endcase
	end

endmodule

/* rtl/v06c_io_top.sv */
`timescale 1ns/1ps

module v06c_io_top (
	input  logic                 clk_sys,
	input  logic                 cold_reset,
	input  logic                 req_i,
	input  v06c_pkg::bus_cycle_t cycle_i,
	input  v06c_pkg::joy_pads_t  pads_i,
	output logic                 ack_o,
	output logic [7:0]           rdata_o,
	output v06c_pkg::mem_map_t   mem_o
);
	import v06c_pkg::*;

	bus_cycle_t cur;
	io_strobe_t strobe;
	joy_views_t views;
	logic [7:0] rd_byte;
	logic       edsk_we;
	logic       joy_we;

	v06c_bus_frontend u_frontend (
		.clk_sys    (clk_sys),
		.cold_reset (cold_reset),
		.req_i      (req_i),
		.cycle_i    (cycle_i),
		.rd_byte_i  (rd_byte),
		.ack_o      (ack_o),
		.cur_o      (cur),
		.strobe_o   (strobe),
		.rdata_o    (rdata_o)
	);

	v06c_io_decode u_decode (
		.cur_i     (cur),
		.strobe_i  (strobe),
		.joy_rd_i  (views),
		.rd_byte_o (rd_byte),
		.edsk_we_o (edsk_we),
		.joy_we_o  (joy_we)
	);

	v06c_edisk_map u_edisk (
		.clk_sys    (clk_sys),
		.cold_reset (cold_reset),
		.cur_i      (cur),
		.mem_acc_i  (strobe.mem_acc),
		.edsk_we_i  (edsk_we),
		.map_o      (mem_o)
	);

	v06c_joy_ports u_joy (
		.clk_sys    (clk_sys),
		.cold_reset (cold_reset),
		.cur_i      (cur),
		.joy_we_i   (joy_we),
		.pads_i     (pads_i),
		.views_o    (views)
	);

endmodule

/* tb/tb_v06c_io.sv */
`timescale 1ns/1ps
`include "v06c_defines.svh"

module tb_v06c_io;
	import v06c_pkg::*;

	localparam int N_JOY     = 300;
	localparam int N_UNDEC   = 40;
	localparam int N_INTA    = 20;
	localparam int N_EDSK    = 300;
	localparam int N_MEM     = 4;
	localparam int N_IOMIX   = 50;
	localparam int N_POST    = 20;
	localparam int N_BUS     = 4 + 2 * N_JOY + N_UNDEC + N_INTA + 2 + N_EDSK * (1 + N_MEM)
		+ 1 + 2 * N_IOMIX + 1 + 4 + N_POST;
	localparam int MAX_CLKS  = 40 * N_BUS + 100;

	logic       clk_sys = 1'b0;
	logic       cold_reset;
	logic       req_i;
	bus_cycle_t cycle_i;
	joy_pads_t  pads_i;
	logic       ack_o;
	logic [7:0] rdata_o;
	mem_map_t   mem_o;

	integer     seed;
	int         clk_cnt = 0;
	logic [7:0] m_edsk;
	logic [7:0] m_joy;
	joy_pads_t  pads_next;

	v06c_io_top dut_i (
		.clk_sys    (clk_sys),
		.cold_reset (cold_reset),
		.req_i      (req_i),
		.cycle_i    (cycle_i),
		.pads_i     (pads_i),
		.ack_o      (ack_o),
		.rdata_o    (rdata_o),
		.mem_o      (mem_o)
	);

	always #10 clk_sys = ~clk_sys;

	// Hang guard
	always @(posedge clk_sys) begin
		clk_cnt <= clk_cnt + 1;
		if (clk_cnt > MAX_CLKS) begin
			$display("Timeout: bus cycles did not complete within %0d clocks", MAX_CLKS);
			$display("Test failures found");
			$fatal(1, "simulation stopped by timeout");
		end
	end

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] time %0t: %s: got %0h, expected %0h", $time, what, got, exp);
			$display("Test failures found");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic logic [31:0] rnd();
		rnd = $random(seed);
	endfunction

	// ------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------

	// Active-low pad view, spare positions 5 and 4 read high
	function automatic logic [7:0] pad_to_view(input logic [7:0] pad);
		logic [7:0] v;
		v[7]   = ~pad[5];
		v[6]   = ~pad[4];
		v[5:4] = 2'b11;
		v[3]   = ~pad[2];
		v[2]   = ~pad[3];
		v[1]   = ~pad[1];
		v[0]   = ~pad[0];
		return v;
	endfunction

	function automatic logic [7:0] merge_pads(input joy_pads_t pads);
		logic [7:0] o;
		o = pads.pad_a | pads.pad_b;
		return {o[3], o[0], o[2], o[1], o[4], o[5], 2'b00};
	endfunction

	function automatic logic [7:0] port_read_value(input bus_cycle_t c);
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] p;
		a = pad_to_view(pads_next.pad_a);
		b = pad_to_view(pads_next.pad_b);
		case (m_joy[6:5])
			2'd0:    p = a & b;
			2'd1:    p = a;
			2'd2:    p = b;
			default: p = 8'hFF;
		endcase
		if (c.status.int_ack || !c.status.io_rd)
			return 8'hFF;
		case (c.addr[7:0])
			`V06C_PORT_JOY_BASE: return 8'h00;
			8'h05:               return 8'h00;
			`V06C_PORT_JOYP:     return p;
			`V06C_PORT_JOYPU:    return merge_pads(pads_next);
			`V06C_PORT_JOYA:     return a;
			`V06C_PORT_JOYB:     return b;
			default:             return 8'hFF;
		endcase
	endfunction

	function automatic mem_map_t mapped_address(input bus_cycle_t c, input logic [7:0] er);
		logic       acc;
		logic       win;
		logic [1:0] q;
		logic [2:0] pg;
		mem_map_t   m;
		acc = (c.status.mem_rd || !c.status.wr_n) && !c.status.io_wr && !c.status.io_rd;
		q   = c.addr[14:13];
		win = c.addr[15] && (q == 2'b01 || q == 2'b10 || (q == 2'b11 && er[7])
			|| (q == 2'b00 && er[6]));
		pg  = 3'd0;
		if (acc && c.status.stack && er[4])
			pg = {1'b0, er[3:2]} + 3'd1;
		else if (acc && win && er[5])
			pg = {1'b0, er[1:0]} + 3'd1;
		m.page     = pg;
		m.ram_addr = {pg, c.addr[15], c.addr[12:0], c.addr[14:13]};
		return m;
	endfunction

	task automatic apply_io_write(input bus_cycle_t c);
		if (c.status.io_wr && !c.status.wr_n) begin
			case (c.addr[7:0])
				`V06C_PORT_EDSK: m_edsk = c.wdata;
				8'h05:           m_joy = c.wdata;
				`V06C_PORT_JOY_BASE: begin
					if (!c.wdata[7])
						m_joy[c.wdata[3:1]] = c.wdata[0];
				end
				default: ;
			endcase
		end
	endtask

	// ------------------------------------------------------------
	// Cycle builders and bus driver
	// ------------------------------------------------------------

	function automatic bus_cycle_t io_cycle(input logic wr, input logic [15:0] addr,
		input logic [7:0] data);
		bus_cycle_t c;
		c = '0;
		c.status.io_wr = wr;
		c.status.io_rd = ~wr;
		c.status.wr_n  = ~wr;
		c.addr         = addr;
		c.wdata        = data;
		return c;
	endfunction

	function automatic bus_cycle_t inta_cycle(input logic [15:0] addr);
		bus_cycle_t c;
		c = '0;
		c.status.int_ack = 1'b1;
		c.status.m1      = 1'b1;
		c.status.io_rd   = 1'b1;
		c.status.wr_n    = 1'b1;
		c.addr           = addr;
		return c;
	endfunction

	function automatic bus_cycle_t mem_cycle(input logic wr, input logic stack,
		input logic [15:0] addr, input logic [7:0] data);
		bus_cycle_t c;
		c = '0;
		c.status.mem_rd = ~wr;
		c.status.wr_n   = ~wr;
		c.status.stack  = stack;
		c.addr          = addr;
		c.wdata         = data;
		return c;
	endfunction

	// One four-phase req/ack transfer, checked against the model
	task automatic run_cycle(input bus_cycle_t c, input string what);
		logic [7:0] exp_rd;
		mem_map_t   exp_mem;
		exp_rd = port_read_value(c);
		apply_io_write(c);
		exp_mem = mapped_address(c, m_edsk);
		@(negedge clk_sys);
		cycle_i = c;
		pads_i  = pads_next;
		req_i   = 1'b1;
		@(negedge clk_sys);
		while (!ack_o)
			@(negedge clk_sys);
		check({24'd0, rdata_o}, {24'd0, exp_rd}, $sformatf("%s rdata, addr %04h", what, c.addr));
		check({10'd0, mem_o}, {10'd0, exp_mem}, $sformatf("%s mem map, addr %04h", what, c.addr));
		req_i = 1'b0;
		@(negedge clk_sys);
		while (ack_o)
			@(negedge clk_sys);
	endtask

	task automatic do_reset();
		cold_reset = 1'b1;
		repeat (3) @(negedge clk_sys);
		cold_reset = 1'b0;
		m_edsk = 8'h00;
		m_joy  = 8'h00;
	endtask

	task automatic new_pads();
		logic [31:0] r;
		r = rnd();
		pads_next = r[15:0];
	endtask

	task automatic read_joy_views(input string what);
		new_pads();
		run_cycle(io_cycle(1'b0, {8'h00, `V06C_PORT_JOYP}, 8'h00), what);
		run_cycle(io_cycle(1'b0, {8'h00, `V06C_PORT_JOYPU}, 8'h00), what);
		run_cycle(io_cycle(1'b0, {8'h00, `V06C_PORT_JOYA}, 8'h00), what);
		run_cycle(io_cycle(1'b0, {8'h00, `V06C_PORT_JOYB}, 8'h00), what);
	endtask

	// ------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------

	initial begin
		logic [31:0] r;
		logic [7:0]  port;
		logic [7:0]  cmd;
		seed      = 32'h6a68;
		req_i     = 1'b0;
		cycle_i   = '0;
		pads_i    = '0;
		pads_next = '0;
		do_reset();

		read_joy_views("views after reset");

		// Bit-set, ignored and full-byte joystick commands
		for (int i = 0; i < N_JOY; i++) begin
			r    = rnd();
			port = `V06C_PORT_JOY_BASE;
			case (r[9:8])
				2'd0, 2'd1: cmd = {1'b0, r[6:0]};
				2'd2:       cmd = {1'b1, r[6:0]};
				default: begin
					cmd  = r[7:0];
					port = 8'h05;
				end
			endcase
			run_cycle(io_cycle(1'b1, {r[23:16], port}, cmd), "joystick write");
			new_pads();
			run_cycle(io_cycle(1'b0, {r[31:24], `V06C_PORT_JOYP}, 8'h00), "P view read");
		end

		for (int i = 0; i < N_UNDEC; i++) begin
			r = rnd();
			while (r[7:0] inside {8'h04, 8'h05, 8'h06, 8'h07, 8'h0E, 8'h0F})
				r = rnd();
			run_cycle(io_cycle(1'b0, r[15:0], 8'h00), "undecoded read");
		end
		// Acknowledge on ports 04 to 07 still reads the idle byte
		for (int i = 0; i < N_INTA; i++) begin
			r = rnd();
			run_cycle(inta_cycle({r[15:8], 6'h01, r[1:0]}), "interrupt acknowledge");
		end
		run_cycle(io_cycle(1'b0, 16'h0004, 8'h00), "port 04 read");
		run_cycle(io_cycle(1'b0, 16'h0005, 8'h00), "port 05 read");

		// E-disk register against window, stack and interleave rules
		for (int i = 0; i < N_EDSK; i++) begin
			r = rnd();
			run_cycle(io_cycle(1'b1, {r[15:8], `V06C_PORT_EDSK}, r[7:0]), "E-disk write");
			for (int j = 0; j < N_MEM; j++) begin
				r = rnd();
				run_cycle(mem_cycle(r[16], r[17], r[15:0], r[31:24]), "memory cycle");
			end
		end

		// Mapping fully on, I/O traffic must leave it alone
		r = rnd();
		run_cycle(io_cycle(1'b1, 16'h0010, {4'hF, r[3:0]}), "E-disk enable");
		for (int i = 0; i < N_IOMIX; i++) begin
			r    = rnd();
			port = (r[7:0] == `V06C_PORT_EDSK) ? 8'h11 : r[7:0];
			run_cycle(io_cycle(r[8], {r[23:16], port}, r[31:24]), "I/O cycle");
			run_cycle(mem_cycle(r[9], 1'b1, {1'b1, r[14:0]}, 8'h00), "stack after I/O");
		end

		// Pad select forced to all ones before the reset
		run_cycle(io_cycle(1'b1, 16'h0005, 8'h60), "joystick preset");

		do_reset();
		read_joy_views("views after second reset");
		for (int i = 0; i < N_POST; i++) begin
			r = rnd();
			run_cycle(mem_cycle(r[16], 1'b1, {1'b1, r[14:0]}, 8'h00), "memory after reset");
		end

		$display("All tests passed!");
		$finish;
	end

endmodule

/* build.f */
+incdir+rtl
rtl/v06c_pkg.sv
rtl/v06c_bus_frontend.sv
rtl/v06c_io_decode.sv
rtl/v06c_edisk_map.sv
rtl/v06c_joy_ports.sv
rtl/v06c_io_top.sv
tb/tb_v06c_io.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_v06c_io \
	-f build.f -o tb_v06c_io_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_v06c_io_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
	echo "Simulation FAILED"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

echo "Simulation PASSED"
exit 0
